//--- cachePkg.sv
package cachePkg;

	localparam int AddrW = 16; // Byte address
	localparam int WordW = 16; // One data word
	localparam int TagW = 5;
	localparam int IndexW = 7; // 128 blocks
	localparam int OffsetW = 3; // 8 words per block

	localparam int OffsetLsb = 1; // Bit 0 selects a byte, never used
	localparam int IndexLsb = OffsetLsb + OffsetW;
	localparam int TagLsb = IndexLsb + IndexW;

	localparam int NumBlocks = 1 << IndexW;
	localparam int BlockWords = 1 << OffsetW;

	typedef logic [TagW-1:0] tagT;
	typedef logic [IndexW-1:0] indexT;
	typedef logic [OffsetW-1:0] offsetT;
	typedef logic [AddrW-1:0] addrT;
	typedef logic [WordW-1:0] wordT;

	typedef struct packed {
		logic valid; // Block holds real data
		tagT tag;
	} metaT;

	typedef struct packed {
		logic write; // 1 write, 0 read
		addrT addr;
		wordT data; // Write data only
	} cpuReqT;

	typedef struct packed {
		wordT data; // Read word or echoed write word
		logic hit; // First lookup found the block
	} cpuRspT;

	typedef struct packed {
		logic write;
		addrT addr;
		wordT data;
	} memReqT;

	typedef enum logic [1:0] {Idle, Lookup, Fill, Finish} ctrlStateT;

endpackage

//--- metaDataArray.sv
`timescale 1ns/1ns

module metaDataArray (
	input logic clk,
	input logic arstN,
	input cachePkg::indexT index, // Entry to read or write
	input logic write, // Update entry at index
	input cachePkg::metaT dataIn,
	output cachePkg::metaT dataOut // Registered read
);

	logic [cachePkg::NumBlocks-1:0] validBits; // One per block, cleared on reset
	cachePkg::tagT tags [cachePkg::NumBlocks]; // Tag store

	// Valid bits and the read register share the reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validBits <= '0;
			dataOut <= '0; // Nothing valid after reset
		end else begin
			if (write) begin
				validBits[index] <= dataIn.valid;
				dataOut <= dataIn; // Bypass new entry to the reader
			end else begin
				dataOut.valid <= validBits[index];
				dataOut.tag <= tags[index];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (write) begin
			tags[index] <= dataIn.tag;
		end
	end

endmodule

//--- dataArray.sv
`timescale 1ns/1ns

module dataArray (
	input logic clk,
	input cachePkg::indexT index, // Block select
	input cachePkg::offsetT offset, // Word within block
	input logic write, // Single word write
	input cachePkg::wordT dataIn,
	output cachePkg::wordT dataOut // Registered read
);

	// 128 blocks of 8 words
	cachePkg::wordT blocks [cachePkg::NumBlocks][cachePkg::BlockWords];

	always_ff @(posedge clk) begin
		if (write) begin
			blocks[index][offset] <= dataIn; // One word per cycle
		end
		dataOut <= blocks[index][offset]; // Old word on same-address write
	end

endmodule

//--- cacheFill.sv
`timescale 1ns/1ns

module cacheFill #(
	parameter int MemLatency = 4 // Memory read latency in cycles
) (
	input logic clk,
	input logic arstN,
	input logic start, // Begin a block fill
	input cachePkg::addrT blockAddr, // Any address in the block
	input logic memRsp, // Read word returning
	input cachePkg::wordT memRspData,
	output logic rdReq, // Memory read strobe
	output cachePkg::addrT rdAddr,
	output logic fillWrite, // Data array word write
	output cachePkg::indexT fillIndex,
	output cachePkg::offsetT fillOffset,
	output cachePkg::wordT fillData,
	output logic done // Last word written
);

	localparam int FlightW = $clog2(MemLatency + 1); // Holds 0..MemLatency

	cachePkg::tagT baseTag; // Latched block tag
	cachePkg::indexT baseIndex; // Latched block index
	cachePkg::tagT rdTag;
	cachePkg::indexT rdIndex;
	cachePkg::offsetT rdOffset;
	logic issuing; // Words 1..7 still to issue
	cachePkg::offsetT issueCnt; // Next word to issue
	cachePkg::offsetT retCnt; // Offset of next returning word
	logic [FlightW-1:0] inFlight; // Reads issued but not returned

	// Word 0 goes out in the start cycle itself
	assign rdReq = start || issuing;
	assign rdTag = start ? blockAddr[cachePkg::TagLsb +: cachePkg::TagW] : baseTag;
	assign rdIndex = start ? blockAddr[cachePkg::IndexLsb +: cachePkg::IndexW] : baseIndex;
	assign rdOffset = start ? cachePkg::offsetT'(0) : issueCnt;
	assign rdAddr = {rdTag, rdIndex, rdOffset, 1'b0};

	// Returns are in issue order, so a counter tags each word
	assign fillWrite = memRsp && (inFlight != '0); // Own reads only
	assign fillIndex = baseIndex;
	assign fillOffset = retCnt;
	assign fillData = memRspData;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			issuing <= 1'b0;
			issueCnt <= '0;
			retCnt <= '0;
			inFlight <= '0;
			done <= 1'b0;
		end else begin
			done <= fillWrite && (retCnt == cachePkg::offsetT'(cachePkg::BlockWords - 1));
			if (start) begin
				issuing <= 1'b1;
				issueCnt <= cachePkg::offsetT'(1); // Word 0 already issued
			end else if (issuing) begin
				issueCnt <= issueCnt + 1'b1;
				if (issueCnt == cachePkg::offsetT'(cachePkg::BlockWords - 1)) begin
					issuing <= 1'b0; // Eighth read out
				end
			end
			if (start) begin
				retCnt <= '0;
			end else if (fillWrite) begin
				retCnt <= retCnt + 1'b1; // Wraps to 0 after word 7
			end
			inFlight <= inFlight + FlightW'(rdReq) - FlightW'(fillWrite);
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			baseTag <= blockAddr[cachePkg::TagLsb +: cachePkg::TagW];
			baseIndex <= blockAddr[cachePkg::IndexLsb +: cachePkg::IndexW];
		end
	end

endmodule

//--- cacheCtrl.sv
`timescale 1ns/1ns

module cacheCtrl #(
	parameter int MemLatency = 4 // Passed to the fill engine
) (
	input logic clk,
	input logic arstN,
	input logic req, // Request strobe
	input cachePkg::cpuReqT reqData,
	input logic memRsp, // Memory read return
	input cachePkg::wordT memRspData,
	output logic rsp, // Response strobe
	output cachePkg::cpuRspT rspData,
	output logic memReq, // Memory request strobe
	output cachePkg::memReqT memReqData
);

	cachePkg::ctrlStateT state;
	cachePkg::cpuReqT curReq; // Request being served
	logic missSeen; // First lookup missed

	cachePkg::tagT reqTag;
	cachePkg::indexT reqIndex;
	cachePkg::offsetT reqOffset;
	cachePkg::indexT lookIndex; // Array read address
	cachePkg::offsetT lookOffset;

	cachePkg::metaT metaOut;
	cachePkg::metaT metaIn;
	cachePkg::wordT wordOut;
	logic hit;
	logic lookupWrite; // Write hit on first lookup
	logic finishWrite; // Write miss applied after fill
	logic ctrlWrite; // Cache and memory write together

	logic fillStart;
	logic fillRdReq;
	cachePkg::addrT fillRdAddr;
	logic fillWrite;
	cachePkg::indexT fillIndex;
	cachePkg::offsetT fillOffset;
	cachePkg::wordT fillData;
	logic fillDone;

	cachePkg::indexT arrIndex; // Data array port, shared with fill
	cachePkg::offsetT arrOffset;
	cachePkg::wordT arrDataIn;

	assign reqTag = curReq.addr[cachePkg::TagLsb +: cachePkg::TagW];
	assign reqIndex = curReq.addr[cachePkg::IndexLsb +: cachePkg::IndexW];
	assign reqOffset = curReq.addr[cachePkg::OffsetLsb +: cachePkg::OffsetW];

	// Idle reads straight from the incoming request so Lookup has data
	assign lookIndex = (state == cachePkg::Idle) ?
		reqData.addr[cachePkg::IndexLsb +: cachePkg::IndexW] : reqIndex;
	assign lookOffset = (state == cachePkg::Idle) ?
		reqData.addr[cachePkg::OffsetLsb +: cachePkg::OffsetW] : reqOffset;

	assign hit = metaOut.valid && (metaOut.tag == reqTag);
	assign lookupWrite = (state == cachePkg::Lookup) && hit && curReq.write && !missSeen;
	assign finishWrite = (state == cachePkg::Finish) && curReq.write;
	assign ctrlWrite = lookupWrite || finishWrite;
	assign fillStart = (state == cachePkg::Lookup) && !hit;

	assign metaIn = '{valid: 1'b1, tag: reqTag}; // Block now resident

	// Fill engine owns the data array write port while words return
	assign arrIndex = fillWrite ? fillIndex : lookIndex;
	assign arrOffset = fillWrite ? fillOffset : lookOffset;
	assign arrDataIn = fillWrite ? fillData : curReq.data;

	// Fill reads and write-through never overlap
	assign memReq = fillRdReq || ctrlWrite;
	always_comb begin
		if (fillRdReq) begin
			memReqData = '{write: 1'b0, addr: fillRdAddr, data: '0};
		end else begin
			memReqData = '{write: 1'b1, addr: curReq.addr, data: curReq.data};
		end
	end

	metaDataArray meta (
		.clk(clk),
		.arstN(arstN),
		.index(lookIndex),
		.write(state == cachePkg::Finish), // Tag and valid set after fill
		.dataIn(metaIn),
		.dataOut(metaOut)
	);

	dataArray data (
		.clk(clk),
		.index(arrIndex),
		.offset(arrOffset),
		.write(fillWrite || ctrlWrite),
		.dataIn(arrDataIn),
		.dataOut(wordOut)
	);

	cacheFill #(
		.MemLatency(MemLatency)
	) fill (
		.clk(clk),
		.arstN(arstN),
		.start(fillStart),
		.blockAddr(curReq.addr),
		.memRsp(memRsp),
		.memRspData(memRspData),
		.rdReq(fillRdReq),
		.rdAddr(fillRdAddr),
		.fillWrite(fillWrite),
		.fillIndex(fillIndex),
		.fillOffset(fillOffset),
		.fillData(fillData),
		.done(fillDone)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= cachePkg::Idle;
			missSeen <= 1'b0;
			rsp <= 1'b0;
		end else begin
			rsp <= 1'b0; // Strobe
			case (state)
				cachePkg::Idle: begin
					if (req) begin // Only accepted here
						missSeen <= 1'b0;
						state <= cachePkg::Lookup;
					end
				end
				cachePkg::Lookup: begin
					if (hit) begin
						rsp <= 1'b1;
						state <= cachePkg::Idle;
					end else begin
						missSeen <= 1'b1;
						state <= cachePkg::Fill;
					end
				end
				cachePkg::Fill: begin
					if (fillDone) state <= cachePkg::Finish;
				end
				cachePkg::Finish: state <= cachePkg::Lookup; // Repeat lookup, now a hit
				default: state <= cachePkg::Idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == cachePkg::Idle) && req) begin
			curReq <= reqData;
		end
		if ((state == cachePkg::Lookup) && hit) begin
			rspData.data <= curReq.write ? curReq.data : wordOut; // Writes echo data
			rspData.hit <= !missSeen;
		end
	end

endmodule

//--- mainMemory.sv
`timescale 1ns/1ns

module mainMemory #(
	parameter int MemLatency = 4 // Read latency, 1 to 8
) (
	input logic clk,
	input logic arstN,
	input logic memReq, // One request per cycle
	input cachePkg::memReqT memReqData,
	output logic memRsp, // Read data valid
	output cachePkg::wordT memRspData
);

	localparam int MemWords = 1 << (cachePkg::AddrW - 1); // Word addressed

	cachePkg::wordT mem [MemWords];
	logic [cachePkg::AddrW-2:0] wordAddr; // Address bits 15..1
	logic rdStrobe;
	logic [MemLatency-1:0] validPipe; // Read return pipeline
	cachePkg::wordT dataPipe [MemLatency];

	assign wordAddr = memReqData.addr[cachePkg::AddrW-1:1];
	assign rdStrobe = memReq && !memReqData.write;

	assign memRsp = validPipe[MemLatency-1];
	assign memRspData = dataPipe[MemLatency-1];

	initial begin
		for (int i = 0; i < MemWords; i++) begin
			mem[i] = '0; // Model starts zero-filled
		end
	end

	always_ff @(posedge clk) begin
		if (memReq && memReqData.write) begin
			mem[wordAddr] <= memReqData.data; // Done in the strobe cycle
		end
		dataPipe[0] <= mem[wordAddr];
		for (int i = 1; i < MemLatency; i++) begin
			dataPipe[i] <= dataPipe[i-1];
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validPipe <= '0;
		end else begin
			validPipe[0] <= rdStrobe;
			for (int i = 1; i < MemLatency; i++) begin
				validPipe[i] <= validPipe[i-1]; // Returns in issue order
			end
		end
	end

endmodule

//--- memSubsystem.sv
`timescale 1ns/1ns

module memSubsystem #(
	parameter int MemLatency = 4 // Memory read latency, 1 to 8
) (
	input logic clk,
	input logic arstN,
	input logic req, // Requester strobe
	input cachePkg::cpuReqT reqData,
	output logic rsp, // Response strobe
	output cachePkg::cpuRspT rspData
);

	logic memReq;
	cachePkg::memReqT memReqData;
	logic memRsp;
	cachePkg::wordT memRspData;

	cacheCtrl #(
		.MemLatency(MemLatency)
	) ctrl (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.reqData(reqData),
		.memRsp(memRsp),
		.memRspData(memRspData),
		.rsp(rsp),
		.rspData(rspData),
		.memReq(memReq),
		.memReqData(memReqData)
	);

	mainMemory #(
		.MemLatency(MemLatency)
	) mem (
		.clk(clk),
		.arstN(arstN),
		.memReq(memReq),
		.memReqData(memReqData),
		.memRsp(memRsp),
		.memRspData(memRspData)
	);

endmodule

//--- clockGen.sv
`timescale 1ns/1ns

module clockGen #(
	parameter int Period = 4 // Clock period in ns
) (
	output logic clk
);

	// Free-running, starts low
	initial begin
		clk = 1'b0;
		forever begin
			#(Period / 2) clk = ~clk; // Half period per phase
		end
	end

endmodule

//--- cacheTb.sv
`timescale 1ns/1ns

module cacheTb;

	localparam int MemLatency = 4;
	localparam int DirectedRows = 19; // Cold miss, fill, eviction, write hit, bit 0
	localparam int MixedRows = 40; // LCG sequence
	localparam int NumRows = DirectedRows + MixedRows;
	localparam int RowCycles = MemLatency + 16; // Miss worst case plus margin

	typedef struct packed {
		logic write; // 1 write, 0 read
		cachePkg::addrT addr;
		cachePkg::wordT data; // Write data
		logic expHit;
		cachePkg::wordT expData; // Read word or echoed write word
	} testRowT;

	logic clk;
	logic arstN;
	logic req;
	cachePkg::cpuReqT reqData;
	logic rsp;
	cachePkg::cpuRspT rspData;

	testRowT rows [NumRows]; // Stimulus and expected values
	logic [31:0] lcgState;
	int rowCount; // Rows added so far
	int passCount;
	int failCount;

	cachePkg::wordT shadow [logic [14:0]]; // Main memory contents by word address
	logic modelValid [128]; // Resident blocks by index
	cachePkg::tagT modelTag [128];

	clockGen #(
		.Period(4)
	) clkSrc (
		.clk(clk)
	);

	memSubsystem #(
		.MemLatency(MemLatency)
	) UUT (
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.reqData(reqData),
		.rsp(rsp),
		.rspData(rspData)
	);

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Two tags, four blocks, any offset, random bit 0
	function automatic cachePkg::addrT mixedAddr(input logic [31:0] r);
		cachePkg::addrT a;
		a = '0;
		a[11] = r[20]; // Tag 0 or 1
		a[5:4] = r[22:21]; // Index 0 to 3
		a[3:0] = r[26:23]; // Offset and byte bit
		return a;
	endfunction

	function automatic void addRow(input logic write, input cachePkg::addrT addr);
		testRowT row;
		lcgState = lcgNext(lcgState);
		row.write = write;
		row.addr = addr;
		row.data = write ? lcgState[30:15] : '0;
		row.expHit = 1'b0; // Filled in by the model
		row.expData = '0;
		rows[rowCount] = row;
		rowCount++;
	endfunction

	function automatic void buildTable();
		cachePkg::addrT a;
		cachePkg::addrT b;
		a = 16'h1234; // Tag 2, index 0x23, offset 2
		b = a ^ 16'h0800; // Same index, other tag
		addRow(1'b1, a); // Cold write miss
		addRow(1'b0, a); // Now resident
		for (int w = 0; w < 8; w++) begin
			addRow(1'b0, {a[15:4], 3'(w), 1'b0}); // Every word of the filled block
		end
		addRow(1'b1, b); // Evicts a
		addRow(1'b0, a); // Refill must see the written-through word
		addRow(1'b0, b);
		addRow(1'b0, a);
		addRow(1'b1, a); // Write hit
		addRow(1'b0, a);
		addRow(1'b1, a | 16'h0001); // Bit 0 set, same word
		addRow(1'b0, a);
		addRow(1'b0, a | 16'h0001);
		for (int m = 0; m < MixedRows; m++) begin
			lcgState = lcgNext(lcgState);
			addRow(lcgState[27], mixedAddr(lcgState));
		end
	endfunction

	// Direct-mapped write-allocate model over the whole table
	function automatic void predict();
		logic [14:0] word;
		logic [6:0] idx;
		logic [4:0] tag;
		for (int i = 0; i < 128; i++) begin
			modelValid[i] = 1'b0; // Cold cache
		end
		for (int r = 0; r < NumRows; r++) begin
			word = rows[r].addr[15:1];
			idx = rows[r].addr[10:4];
			tag = rows[r].addr[15:11];
			rows[r].expHit = modelValid[idx] && (modelTag[idx] == tag);
			modelValid[idx] = 1'b1; // Any access allocates
			modelTag[idx] = tag;
			if (rows[r].write) begin
				shadow[word] = rows[r].data;
				rows[r].expData = rows[r].data; // Echo
			end else if (shadow.exists(word)) begin
				rows[r].expData = shadow[word];
			end else begin
				rows[r].expData = '0; // Memory starts zero-filled
			end
		end
	endfunction

	task automatic applyRow(input int r);
		testRowT row;
		int waited;
		row = rows[r];
		waited = 0;
		@(posedge clk);
		req <= 1'b1;
		reqData <= '{write: row.write, addr: row.addr, data: row.data};
		@(posedge clk);
		req <= 1'b0; // One-cycle strobe
		do begin
			@(negedge clk); // Outputs settled
			waited++;
		end while (!rsp && waited < RowCycles);
		if (!rsp) begin
			$display("Row %0d got no response within %0d cycles", r, RowCycles);
			failCount++;
		end else if (rspData.hit !== row.expHit || rspData.data !== row.expData) begin
			$display("FAILED at %0t: row %0d %s addr %h expected hit %b data %h, got hit %b data %h",
				$time, r, row.write ? "write" : "read", row.addr, row.expHit, row.expData,
				rspData.hit, rspData.data);
			failCount++;
		end else begin
			$display("Row %0d %s addr %h hit %b data %h ok",
				r, row.write ? "write" : "read", row.addr, rspData.hit, rspData.data);
			passCount++;
		end
	endtask

	initial begin
		arstN = 1'b0;
		req = 1'b0;
		reqData = '0;
		lcgState = 32'd34; // Seed
		rowCount = 0;
		passCount = 0;
		failCount = 0;
		buildTable();
		predict();
		repeat (8) @(posedge clk);
		arstN <= 1'b1;
		for (int r = 0; r < NumRows; r++) begin
			applyRow(r);
		end
		$display("Rows %0d, passed %0d, failed %0d", NumRows, passCount, failCount);
		if (failCount == 0 && rowCount == NumRows) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// Hang guard sized from the table
	initial begin
		repeat (NumRows * RowCycles + 64) @(posedge clk);
		$display("Watchdog expired, the DUT stopped responding");
		$display("test failed");
		$finish;
	end

endmodule

//--- build.f
cachePkg.sv
metaDataArray.sv
dataArray.sv
cacheFill.sv
cacheCtrl.sv
mainMemory.sv
memSubsystem.sv
clockGen.sv
cacheTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module cacheTb -f build.f -o cacheSim
	./obj_dir/cacheSim | tee sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
